/* verilog.f */
+incdir+design
design/soc_pkg.sv
design/ls_dec.sv
design/soc_mem.sv
design/soc_gpio.sv
design/soc_top.sv
test/soc_tb.sv

/* Makefile */
# Verilator flow for the load/store SoC testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= soc_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

FAIL_MSG := Simulation failed
PASS_MSG := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "result: FAIL"; \
	  exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "result: FAIL, run ended without a verdict"; \
	  exit 1; \
	else \
	  echo "result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/soc_tb.sv */
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_tb;

  localparam int EDGE_LIMIT = 20;  // ns allowed per falling edge at a 10 ns clock
  localparam int N_WORDS    = 40;  // words in the full-word pass

  logic               clk = 1'b0;
  logic               arst_n;
  logic [`SOC_AW-1:0] mem_addr;
  logic [`SOC_DW-1:0] mem_wdata;
  logic [`SOC_BW-1:0] mem_wmask;
  logic               mem_rstrb;
  logic [`SOC_DW-1:0] mem_rdata;
  logic [`SOC_GW-1:0] gpio_o;
  logic [`SOC_GW-1:0] gpio_e;
  logic [`SOC_GW-1:0] gpio_i;

  // reference model
  logic [`SOC_DW-1:0]     mem_ref [0:2**`SOC_MEM_AW-1];
  logic [`SOC_GW-1:0]     out_ref;
  logic [`SOC_GW-1:0]     ena_ref;
  logic [`SOC_GW-1:0]     inp_ref;  // value held on the pins
  logic [`SOC_MEM_AW-1:0] used [N_WORDS];  // indices hit by the full-word pass

  int seed = 32'h3b3160f7;

  always #5 clk = ~clk;

  soc_top i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rstrb (mem_rstrb),
    .mem_rdata (mem_rdata),
    .gpio_o    (gpio_o),
    .gpio_e    (gpio_e),
    .gpio_i    (gpio_i)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_value(input string what);
    abort_run($sformatf("[FAIL] %0t ns: %s", $time, what));
  endtask

  // one full cycle up to the next falling edge
  task automatic wait_fall();
    int unsigned ns;
    ns = 0;
    while (clk !== 1'b1 && ns < EDGE_LIMIT) begin  // leave the low phase
      #1;
      ns++;
    end
    while (clk !== 1'b0 && ns < EDGE_LIMIT) begin
      #1;
      ns++;
    end
    if (ns >= EDGE_LIMIT) begin
      abort_run("timeout: clock stopped toggling, no falling edge seen");
    end
  endtask

  task automatic rand_word(output logic [`SOC_DW-1:0] w);
    w = $random(seed);
  endtask

  // byte lanes with a mask bit set take the new value
  function automatic logic [`SOC_DW-1:0] apply_mask(
    input logic [`SOC_DW-1:0] old_w,
    input logic [`SOC_DW-1:0] new_w,
    input logic [`SOC_BW-1:0] m
  );
    logic [`SOC_DW-1:0] bits;
    for (int i = 0; i < `SOC_DW; i++) begin
      bits[i] = m[i/8];
    end
    return (old_w & ~bits) | (new_w & bits);
  endfunction

  function automatic logic [`SOC_AW-1:0] mem_adr(input logic [`SOC_MEM_AW-1:0] idx);
    return {1'b0, idx, 2'b00};  // lower half
  endfunction

  function automatic logic [`SOC_AW-1:0] gpio_adr(input logic [1:0] rix);
    return {1'b1, {(`SOC_AW-5){1'b0}}, rix, 2'b00};  // upper half at offset rix*4
  endfunction

  function automatic logic [`SOC_DW-1:0] gpio_exp(input logic [1:0] rix);
    case (rix)
      `SOC_GPIO_OUT: return out_ref;
      `SOC_GPIO_ENA: return ena_ref;
      `SOC_GPIO_INP: return inp_ref;
      default:       return '0;  // unmapped index
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // core port driver
  //////////////////////////////////////////////////////////////////////

  // one-cycle write strobe with the model updated per the address map
  task automatic store(input logic [`SOC_AW-1:0] a, input logic [`SOC_DW-1:0] d,
                       input logic [`SOC_BW-1:0] m);
    mem_addr  = a;
    mem_wdata = d;
    mem_wmask = m;
    mem_rstrb = 1'b0;
    if (!a[`SOC_AW-1]) begin
      mem_ref[a[`SOC_AW-2:2]] = apply_mask(mem_ref[a[`SOC_AW-2:2]], d, m);
    end else if (a[3:2] == `SOC_GPIO_OUT) begin
      out_ref = apply_mask(out_ref, d, m);
    end else if (a[3:2] == `SOC_GPIO_ENA) begin
      ena_ref = apply_mask(ena_ref, d, m);
    end  // input register and index 3 keep nothing
    wait_fall();
    mem_wmask = '0;
  endtask

  // data is stable by the falling edge after the strobe
  task automatic load(input logic [`SOC_AW-1:0] a, output logic [`SOC_DW-1:0] d);
    mem_addr  = a;
    mem_wmask = '0;
    mem_rstrb = 1'b1;
    wait_fall();
    mem_rstrb = 1'b0;
    d = mem_rdata;
  endtask

  task automatic check_mem(input logic [`SOC_MEM_AW-1:0] idx);
    logic [`SOC_DW-1:0] got;
    load(mem_adr(idx), got);
    assert (got === mem_ref[idx])
      else fail_value($sformatf("mem word %0d read %h, expected %h", idx, got, mem_ref[idx]));
  endtask

  task automatic check_gpio(input logic [1:0] rix);
    logic [`SOC_DW-1:0] got;
    load(gpio_adr(rix), got);
    assert (got === gpio_exp(rix))
      else fail_value($sformatf("gpio reg %0d read %h, expected %h", rix, got, gpio_exp(rix)));
  endtask

  task automatic check_pins();
    assert (gpio_o === out_ref)
      else fail_value($sformatf("gpio_o is %h, expected %h", gpio_o, out_ref));
    assert (gpio_e === ena_ref)
      else fail_value($sformatf("gpio_e is %h, expected %h", gpio_e, ena_ref));
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [`SOC_DW-1:0]     r;
    logic [`SOC_DW-1:0]     d;
    logic [`SOC_BW-1:0]     m;
    logic [`SOC_MEM_AW-1:0] idx;
    logic [1:0]             rix;
    arst_n    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wmask = '0;
    mem_rstrb = 1'b0;
    gpio_i    = '0;
    out_ref   = '0;
    ena_ref   = '0;
    inp_ref   = '0;
    wait_fall();
    wait_fall();
    arst_n = 1'b1;  // released on a falling edge

    // reset values
    check_pins();
    check_gpio(`SOC_GPIO_OUT);
    check_gpio(`SOC_GPIO_ENA);

    // full words each read back in the very next cycle
    for (int i = 0; i < N_WORDS; i++) begin
      rand_word(r);
      idx = r[`SOC_MEM_AW-1:0];
      used[i] = idx;
      rand_word(d);
      store(mem_adr(idx), d, '1);
      check_mem(idx);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      check_mem(used[i]);
    end

    // partial masks over words that hold known data
    for (int i = 0; i < 24; i++) begin
      rand_word(r);
      idx = used[int'(r[5:0]) % N_WORDS];
      m = r[11:8];
      if (m == '0) begin
        m = 4'b0110;
      end
      rand_word(d);
      store(mem_adr(idx), d, m);
      check_mem(idx);
    end

    // output and enable registers with pins one cycle after the strobe
    for (int i = 0; i < 16; i++) begin
      rand_word(r);
      rix = r[0] ? `SOC_GPIO_ENA : `SOC_GPIO_OUT;
      m = r[7:4];
      if (m == '0) begin
        m = '1;
      end
      rand_word(d);
      store(gpio_adr(rix), d, m);
      check_pins();
      check_gpio(rix);
    end
    rand_word(d);
    store(gpio_adr(`SOC_GPIO_INP), d, '1);  // read-only register
    check_pins();
    check_gpio(`SOC_GPIO_OUT);
    check_gpio(`SOC_GPIO_ENA);
    check_gpio(`SOC_GPIO_INP);  // still the synchronized pins
    check_gpio(2'd3);

    // input pins through the synchronizer
    rand_word(d);
    gpio_i  = d;
    inp_ref = d;
    for (int i = 0; i < 3; i++) begin
      wait_fall();
    end
    check_gpio(`SOC_GPIO_INP);

    // regions stay apart
    for (int i = 0; i < 3; i++) begin
      rand_word(d);
      store(mem_adr(`SOC_MEM_AW'(i)), d, '1);
    end
    for (int i = 0; i < 3; i++) begin
      rand_word(d);
      store(gpio_adr(2'(i)), d, '1);  // offsets 0, 4, 8
    end
    for (int i = 0; i < 3; i++) begin
      check_mem(`SOC_MEM_AW'(i));
    end
    for (int i = 0; i < 3; i++) begin
      rand_word(d);
      store(mem_adr(`SOC_MEM_AW'(i)), d, '1);
    end
    check_pins();
    check_gpio(`SOC_GPIO_OUT);
    check_gpio(`SOC_GPIO_ENA);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* design/soc_top.sv */
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_top import soc_pkg::*; (
  // system
  input  logic              clk,
  input  logic              arst_n,
  // core load/store port
  input  logic [`SOC_AW-1:0] mem_addr,   // byte address
  input  logic [`SOC_DW-1:0] mem_wdata,  // store data
  input  logic [`SOC_BW-1:0] mem_wmask,  // store byte mask, nonzero = write
  input  logic              mem_rstrb,  // load strobe
  output logic [`SOC_DW-1:0] mem_rdata,  // load data, one cycle later
  // GPIO pins
  output logic [`SOC_GW-1:0] gpio_o,
  output logic [`SOC_GW-1:0] gpio_e,
  input  logic [`SOC_GW-1:0] gpio_i
);

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  // shared request fields, valid split per slave
  logic              ls_mem_vld;
  logic              ls_gpio_vld;
  logic              ls_wen;
  logic [`SOC_BW-1:0] ls_ben;
  soc_adr_u          ls_adr;
  logic [`SOC_DW-1:0] ls_wdt;
  // per slave read data
  logic [`SOC_DW-1:0] ls_mem_rdt;
  logic [`SOC_DW-1:0] ls_gpio_rdt;

  //////////////////////////////////////////////////////////////////////
  // decoder, lower half RAM, upper half GPIO
  //////////////////////////////////////////////////////////////////////

  ls_dec i_dec (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rstrb (mem_rstrb),
    .mem_rdata (mem_rdata),
    .mem_vld   (ls_mem_vld),
    .gpio_vld  (ls_gpio_vld),
    .wen       (ls_wen),
    .ben       (ls_ben),
    .adr       (ls_adr),
    .wdt       (ls_wdt),
    .mem_rdt   (ls_mem_rdt),
    .gpio_rdt  (ls_gpio_rdt)
  );

  // data RAM, behavioral
  soc_mem i_mem (
    .clk (clk),
    .vld (ls_mem_vld),
    .wen (ls_wen),
    .ben (ls_ben),
    .adr (ls_adr),
    .wdt (ls_wdt),
    .rdt (ls_mem_rdt)
  );

  // GPIO controller
  soc_gpio i_gpio (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (ls_gpio_vld),
    .wen    (ls_wen),
    .ben    (ls_ben),
    .adr    (ls_adr),
    .wdt    (ls_wdt),
    .rdt    (ls_gpio_rdt),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule: soc_top

/* design/soc_gpio.sv */
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_gpio import soc_pkg::*; (
  // system
  input  logic              clk,
  input  logic              arst_n,
  // request
  input  logic              vld,
  input  logic              wen,
  input  logic [`SOC_BW-1:0] ben,
  input  soc_adr_u          adr,
  input  logic [`SOC_DW-1:0] wdt,
  // response
  output logic [`SOC_DW-1:0] rdt,
  // pins
  output logic [`SOC_GW-1:0] gpio_o,  // output value
  output logic [`SOC_GW-1:0] gpio_e,  // output enable
  input  logic [`SOC_GW-1:0] gpio_i   // async input
);

  logic [`SOC_GW-1:0] gpio_s1;  // first sync stage, may be metastable
  logic [`SOC_GW-1:0] gpio_s2;  // second sync stage, safe to read

  logic wr_out;  // write to output register
  logic wr_ena;  // write to enable register

  // replace the enabled byte lanes of old with new
  function automatic logic [`SOC_GW-1:0] byte_merge (
    input logic [`SOC_GW-1:0] old_val,
    input logic [`SOC_DW-1:0] new_val,
    input logic [`SOC_BW-1:0] be
  );
    logic [`SOC_GW-1:0] res;
    res = old_val;
    for (int unsigned b = 0; b < `SOC_GW/8; b++) begin
      if (be[b]) res[8*b+:8] = new_val[8*b+:8];
    end
    return res;
  endfunction: byte_merge

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  assign wr_out = vld & wen & (adr.gpio.rix == `SOC_GPIO_OUT);
  assign wr_ena = vld & wen & (adr.gpio.rix == `SOC_GPIO_ENA);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;  // all pins start as inputs
    end else begin
      if (wr_out) gpio_o <= byte_merge(gpio_o, wdt, ben);
      if (wr_ena) gpio_e <= byte_merge(gpio_e, wdt, ben);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // input synchronizer and read mux
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_s1 <= '0;
      gpio_s2 <= '0;
    end else begin
      gpio_s1 <= gpio_i;
      gpio_s2 <= gpio_s1;
    end
  end

  // registered read, latency 1, holds between reads
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdt <= '0;
    end else if (vld && !wen) begin
      case (adr.gpio.rix)
        `SOC_GPIO_OUT: rdt <= gpio_o;
        `SOC_GPIO_ENA: rdt <= gpio_e;
        `SOC_GPIO_INP: rdt <= gpio_s2;
        default:       rdt <= '0;  // index 3 unmapped
      endcase
    end
  end

endmodule: soc_gpio

/* design/soc_mem.sv */
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_mem import soc_pkg::*; (
  input  logic              clk,
  // request
  input  logic              vld,
  input  logic              wen,
  input  logic [`SOC_BW-1:0] ben,
  input  soc_adr_u          adr,
  input  logic [`SOC_DW-1:0] wdt,
  // response
  output logic [`SOC_DW-1:0] rdt
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // 2048 x 32, contents undefined after power up
  logic [`SOC_DW-1:0] mem [0:2**`SOC_MEM_AW-1];

  logic [`SOC_MEM_AW-1:0] idx;  // word index from the mem view

  assign idx = adr.mem.idx;  // byte offset ignored, word access only

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // byte lanes written separately
  always_ff @(posedge clk) begin
    if (vld && wen) begin
      for (int unsigned b = 0; b < `SOC_BW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b+:8] <= wdt[8*b+:8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // registered, latency 1
  // holds the last read word while idle or writing
  always_ff @(posedge clk) begin
    if (vld && !wen) begin
      rdt <= mem[idx];
    end
  end

endmodule: soc_mem

/* design/ls_dec.sv */
`timescale 1ns/1ns
`include "soc_macros.svh"

module ls_dec import soc_pkg::*; (
  // system
  input  logic              clk,
  input  logic              arst_n,
  // core side
  input  logic [`SOC_AW-1:0] mem_addr,
  input  logic [`SOC_DW-1:0] mem_wdata,
  input  logic [`SOC_BW-1:0] mem_wmask,
  input  logic              mem_rstrb,
  output logic [`SOC_DW-1:0] mem_rdata,
  // slave requests
  output logic              mem_vld,   // to data RAM
  output logic              gpio_vld,  // to GPIO
  output logic              wen,
  output logic [`SOC_BW-1:0] ben,
  output soc_adr_u          adr,
  output logic [`SOC_DW-1:0] wdt,
  // slave read data
  input  logic [`SOC_DW-1:0] mem_rdt,
  input  logic [`SOC_DW-1:0] gpio_rdt
);

  logic vld;     // any request this cycle
  logic rd_sel;  // region of the latest read, 1 = GPIO

  //////////////////////////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////////////////////////

  assign wen = |mem_wmask;             // write wins over read
  assign vld = wen | mem_rstrb;
  assign ben = wen ? mem_wmask : '1;   // reads take the full word
  assign adr = soc_adr_u'(mem_addr);
  assign wdt = mem_wdata;

  // region steering, exactly one slave sees vld
  assign mem_vld  = vld & ~adr.mem.sel;
  assign gpio_vld = vld &  adr.mem.sel;

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // remember where the last read went
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_sel <= 1'b0;
    end else if (vld && !wen) begin
      rd_sel <= adr.mem.sel;
    end
  end

  // both slaves hold rdt between reads, so the mux output holds too
  assign mem_rdata = rd_sel ? gpio_rdt : mem_rdt;

endmodule: ls_dec

/* design/soc_pkg.sv */
`include "soc_macros.svh"

package soc_pkg;

  // one bus address, two decodings
  // bit 13 selects the region in both views
  typedef union packed {
    // lower half, data RAM
    struct packed {
      logic                   sel;  // region select, 0 here
      logic [`SOC_MEM_AW-1:0] idx;  // word index
      logic [1:0]             off;  // byte offset
    } mem;
    // upper half, GPIO registers
    struct packed {
      logic                   sel;  // region select, 1 here
      logic [`SOC_AW-6:0]     rsv;  // not decoded
      logic [1:0]             rix;  // register index
      logic [1:0]             off;  // byte offset
    } gpio;
  } soc_adr_u;

endpackage: soc_pkg

/* design/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// core port widths
`define SOC_AW     14             // byte address
`define SOC_DW     32             // data
`define SOC_BW     (`SOC_DW/8)    // byte enables per word

// GPIO pin count
`define SOC_GW     32

// data RAM word address, 2048 words in the lower 8 KiB
`define SOC_MEM_AW 11

// GPIO register index, byte offset is index*4
`define SOC_GPIO_OUT 2'd0  // output value
`define SOC_GPIO_ENA 2'd1  // output enable
`define SOC_GPIO_INP 2'd2  // synchronized input

`endif
